// File: verilog/sys_pkg.sv
`default_nettype none

package sys_pkg;

  // ******************************
  // widths
  // ******************************
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [2:0]  sys_op_t;

  localparam sys_op_t OP_NOP   = 3'd0;
  localparam sys_op_t OP_ADDI  = 3'd1;
  localparam sys_op_t OP_CSRRW = 3'd2;
  localparam sys_op_t OP_CSRRS = 3'd3;
  localparam sys_op_t OP_ECALL = 3'd4;
  localparam sys_op_t OP_MRET  = 3'd5;

  // ******************************
  // machine csrs
  // ******************************
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MVENDORID = 12'hf11;
  localparam csr_addr_t CSR_MARCHID   = 12'hf12;

  localparam xlen_t MCAUSE_ECALL_M = 32'd11; // environment call from m-mode.
  localparam int    MSTATUS_MIE    = 3;
  localparam int    MSTATUS_MPIE   = 7;

  typedef struct packed {
    sys_op_t   op;
    csr_addr_t addr;
    xlen_t     wdata;  // rs1 value for the csr forms.
    xlen_t     pc;     // pc of the instruction, saved into mepc on ecall.
  } csr_req_t;

  typedef struct packed {
    xlen_t     pc;
    logic      rd_we;
    reg_addr_t rd;
    xlen_t     rd_wdata;
    xlen_t     next_pc;
  } retire_t;

endpackage

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire logic          clk_i,
  input  wire logic          reset_i,
  input  wire logic          we_i,
  input  sys_pkg::reg_addr_t waddr_i,
  input  sys_pkg::reg_addr_t raddr_i,
  input  sys_pkg::xlen_t     wdata_i,
  output sys_pkg::xlen_t     rdata_o
);

  sys_pkg::xlen_t regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // a write on this edge is seen by the next instruction through the array itself.
  assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file #(
  parameter sys_pkg::xlen_t VENDOR_ID = 32'h7973_7978,
  parameter sys_pkg::xlen_t ARCH_ID   = 32'h0150_9be8
) (
  input  wire logic         clk_i,
  input  wire logic         reset_i,
  input  wire logic         we_i,
  input  sys_pkg::csr_req_t req_i,
  output sys_pkg::xlen_t    rdata_o,
  output sys_pkg::xlen_t    trap_pc_o
);

  sys_pkg::xlen_t mstatus_q;
  sys_pkg::xlen_t mtvec_q;
  sys_pkg::xlen_t mepc_q;
  sys_pkg::xlen_t mcause_q;
  sys_pkg::xlen_t csr_old;
  sys_pkg::xlen_t csr_new;

  // ******************************
  // read mux
  // ******************************
  always_comb begin
    case (req_i.addr)
      sys_pkg::CSR_MSTATUS:   csr_old = mstatus_q;
      sys_pkg::CSR_MTVEC:     csr_old = mtvec_q;
      sys_pkg::CSR_MEPC:      csr_old = mepc_q;
      sys_pkg::CSR_MCAUSE:    csr_old = mcause_q;
      sys_pkg::CSR_MVENDORID: csr_old = VENDOR_ID;
      sys_pkg::CSR_MARCHID:   csr_old = ARCH_ID;
      default:                csr_old = '0;  // unknown csrs read as zero.
    endcase
  end

  assign rdata_o = csr_old;
  assign csr_new = (req_i.op == sys_pkg::OP_CSRRS) ? (csr_old | req_i.wdata) : req_i.wdata;

  // Trap vector is word aligned; the mode bits of mtvec are ignored.
  assign trap_pc_o = (req_i.op == sys_pkg::OP_MRET) ? mepc_q : {mtvec_q[31:2], 2'b00};

  // ******************************
  // updates
  // ******************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (we_i) begin
      case (req_i.op)
        sys_pkg::OP_CSRRW,
        sys_pkg::OP_CSRRS: begin
          case (req_i.addr)
            sys_pkg::CSR_MSTATUS: mstatus_q <= csr_new;
            sys_pkg::CSR_MTVEC:   mtvec_q   <= csr_new;
            sys_pkg::CSR_MEPC:    mepc_q    <= csr_new;
            sys_pkg::CSR_MCAUSE:  mcause_q  <= csr_new;
            default: ;  // read-only and unknown csrs drop the write.
          endcase
        end
        sys_pkg::OP_ECALL: begin
          mepc_q                         <= req_i.pc;
          mcause_q                       <= sys_pkg::MCAUSE_ECALL_M;
          mstatus_q[sys_pkg::MSTATUS_MPIE] <= mstatus_q[sys_pkg::MSTATUS_MIE];
          mstatus_q[sys_pkg::MSTATUS_MIE]  <= 1'b0;
        end
        sys_pkg::OP_MRET: begin
          mstatus_q[sys_pkg::MSTATUS_MIE]  <= mstatus_q[sys_pkg::MSTATUS_MPIE];
          mstatus_q[sys_pkg::MSTATUS_MPIE] <= 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit #(
  parameter sys_pkg::xlen_t RESET_PC = '0
) (
  input  wire logic      clk_i,
  input  wire logic      reset_i,
  input  wire logic      we_i,
  input  sys_pkg::xlen_t next_pc_i,
  output sys_pkg::xlen_t pc_o
);

  sys_pkg::xlen_t pc_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q <= {RESET_PC[31:2], 2'b00};
    end else if (we_i) begin
      pc_q <= {next_pc_i[31:2], 2'b00};  // keeps the pc word aligned.
    end
  end

  assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: verilog/sys_control.sv
`timescale 1ns/1ps
`default_nettype none

module sys_control (
  input  wire logic              clk_i,
  input  wire logic              reset_i,
  input  wire logic              instr_valid_i,
  input  sys_pkg::xlen_t         instr_i,
  output sys_pkg::reg_addr_t     rs1_addr_o,
  input  sys_pkg::xlen_t         rs1_data_i,
  output logic                   rd_we_o,
  output sys_pkg::reg_addr_t     rd_addr_o,
  output sys_pkg::xlen_t         rd_wdata_o,
  output sys_pkg::csr_req_t      csr_req_o,
  output logic                   csr_we_o,
  input  sys_pkg::xlen_t         csr_rdata_i,
  input  sys_pkg::xlen_t         trap_pc_i,
  input  sys_pkg::xlen_t         pc_i,
  output logic                   pc_we_o,
  output sys_pkg::xlen_t         next_pc_o,
  output logic                   retire_valid_o,
  output sys_pkg::retire_t       retire_o
);

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [11:0]      imm12;
  sys_pkg::xlen_t   imm_sext;
  sys_pkg::sys_op_t op;
  logic             is_csr;
  logic             is_trap;
  logic             retire_valid_q;
  sys_pkg::retire_t retire_q;

  assign opcode   = instr_i[6:0];
  assign funct3   = instr_i[14:12];
  assign imm12    = instr_i[31:20];
  assign imm_sext = {{20{imm12[11]}}, imm12};

  // ******************************
  // decode
  // ******************************
  always_comb begin
    op = sys_pkg::OP_NOP;
    if (opcode == OPC_OP_IMM && funct3 == 3'd0) begin
      op = sys_pkg::OP_ADDI;
    end else if (opcode == OPC_SYSTEM) begin
      case (funct3)
        3'd1: op = sys_pkg::OP_CSRRW;
        3'd2: op = sys_pkg::OP_CSRRS;
        3'd0: begin
          if (imm12 == 12'h000) begin
            op = sys_pkg::OP_ECALL;
          end else if (imm12 == 12'h302) begin
            op = sys_pkg::OP_MRET;
          end
        end
        default: op = sys_pkg::OP_NOP;
      endcase
    end
  end

  assign is_csr  = (op == sys_pkg::OP_CSRRW) || (op == sys_pkg::OP_CSRRS);
  assign is_trap = (op == sys_pkg::OP_ECALL) || (op == sys_pkg::OP_MRET);

  assign rs1_addr_o = instr_i[19:15];
  assign rd_addr_o  = instr_i[11:7];
  assign rd_we_o    = instr_valid_i && (is_csr || op == sys_pkg::OP_ADDI)
                      && (rd_addr_o != '0); // x0 is never written.
  assign rd_wdata_o = is_csr ? csr_rdata_i : rs1_data_i + imm_sext;

  assign csr_req_o = '{op: op, addr: imm12, wdata: rs1_data_i, pc: pc_i};
  assign csr_we_o  = instr_valid_i && (is_csr || is_trap);

  assign pc_we_o   = instr_valid_i;
  assign next_pc_o = is_trap ? trap_pc_i : pc_i + 32'd4;

  // ******************************
  // retire
  // ******************************
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i) begin
      retire_q.pc       <= pc_i;
      retire_q.rd_we    <= rd_we_o;
      retire_q.rd       <= rd_we_o ? rd_addr_o : '0;  // no write shows as rd 0 and data 0.
      retire_q.rd_wdata <= rd_we_o ? rd_wdata_o : '0;
      retire_q.next_pc  <= next_pc_o;
    end
  end

  assign retire_valid_o = retire_valid_q;
  assign retire_o       = retire_q;

endmodule

`default_nettype wire

// File: verilog/sys_core.sv
`timescale 1ns/1ps
`default_nettype none

module sys_core #(
  parameter sys_pkg::xlen_t RESET_PC  = '0,
  parameter sys_pkg::xlen_t VENDOR_ID = 32'h7973_7978,
  parameter sys_pkg::xlen_t ARCH_ID   = 32'h0150_9be8
) (
  input  wire logic        clk_i,
  input  wire logic        reset_i,
  input  wire logic        instr_valid_i,
  input  sys_pkg::xlen_t   instr_i,
  output logic             retire_valid_o,
  output sys_pkg::retire_t retire_o,
  output sys_pkg::xlen_t   pc_o
);

  sys_pkg::reg_addr_t rs1_addr;
  sys_pkg::xlen_t     rs1_data;
  logic               rd_we;
  sys_pkg::reg_addr_t rd_addr;
  sys_pkg::xlen_t     rd_wdata;
  sys_pkg::csr_req_t  csr_req;
  logic               csr_we;
  sys_pkg::xlen_t     csr_rdata;
  sys_pkg::xlen_t     trap_pc;
  sys_pkg::xlen_t     pc;
  logic               pc_we;
  sys_pkg::xlen_t     next_pc;

  // ******************************
  // control
  // ******************************
  sys_control i_control (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .rs1_addr_o     (rs1_addr),
    .rs1_data_i     (rs1_data),
    .rd_we_o        (rd_we),
    .rd_addr_o      (rd_addr),
    .rd_wdata_o     (rd_wdata),
    .csr_req_o      (csr_req),
    .csr_we_o       (csr_we),
    .csr_rdata_i    (csr_rdata),
    .trap_pc_i      (trap_pc),
    .pc_i           (pc),
    .pc_we_o        (pc_we),
    .next_pc_o      (next_pc),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  // ******************************
  // state
  // ******************************
  reg_file i_reg_file (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .we_i    (rd_we),
    .waddr_i (rd_addr),
    .raddr_i (rs1_addr),
    .wdata_i (rd_wdata),
    .rdata_o (rs1_data)
  );

  csr_file #(
    .VENDOR_ID (VENDOR_ID),
    .ARCH_ID   (ARCH_ID)
  ) i_csr_file (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .we_i      (csr_we),
    .req_i     (csr_req),
    .rdata_o   (csr_rdata),
    .trap_pc_o (trap_pc)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) i_pc_unit (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .we_i      (pc_we),
    .next_pc_i (next_pc),
    .pc_o      (pc)
  );

  assign pc_o = pc;

endmodule

`default_nettype wire

// File: dv/sys_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sys_checker (
  input  wire logic             clk_i,
  input  wire logic             retire_valid_i,
  input  wire sys_pkg::retire_t retire_i,
  input  wire sys_pkg::xlen_t   pc_i,
  input  wire logic             exp_valid_i,
  input  wire logic [15:0]      exp_test_i,
  input  wire sys_pkg::retire_t exp_i,
  output int                    pass_count_o,
  output int                    fail_count_o,
  output int                    extra_count_o,
  output int                    pending_o
);

  sys_pkg::retire_t exp_q [$];
  logic [15:0]      test_q [$];
  int               issue_q [$];  // edge on which each expected record was issued.
  int               edge_count;

  initial begin
    pass_count_o  = 0;
    fail_count_o  = 0;
    extra_count_o = 0;
    pending_o     = 0;
    edge_count    = 0;
  end

  function automatic int check_field(input string name, input sys_pkg::xlen_t exp_val,
                                     input sys_pkg::xlen_t act_val);
    if (exp_val !== act_val) begin
      $display("mismatch at %0d ns: %s expected %h actual %h", $time, name, exp_val, act_val);
      return 1;
    end
    return 0;
  endfunction

  // ******************************
  // compare on retire
  // ******************************
  always @(posedge clk_i) begin
    sys_pkg::retire_t exp_rec;
    logic [15:0]      test_num;
    int               issue_edge;
    int               errs;
    edge_count = edge_count + 1;
    if (exp_valid_i) begin
      exp_q.push_back(exp_i);
      test_q.push_back(exp_test_i);
      issue_q.push_back(edge_count);
    end
    if (retire_valid_i) begin
      if (exp_q.size() == 0) begin
        $display("retire of pc %h at %0d ns came with no expected record", retire_i.pc, $time);
        extra_count_o <= extra_count_o + 1;
      end else begin
        exp_rec    = exp_q.pop_front();
        test_num   = test_q.pop_front();
        issue_edge = issue_q.pop_front();
        errs       = 0;
        if (edge_count != issue_edge + 1) begin
          $display("test %0d retired %0d cycles after its strobe instead of one", test_num,
                   edge_count - issue_edge);
          errs += 1;
        end
        errs += check_field("retire_o.pc", exp_rec.pc, retire_i.pc);
        errs += check_field("retire_o.rd_we", {31'b0, exp_rec.rd_we}, {31'b0, retire_i.rd_we});
        errs += check_field("retire_o.rd", {27'b0, exp_rec.rd}, {27'b0, retire_i.rd});
        errs += check_field("retire_o.rd_wdata", exp_rec.rd_wdata, retire_i.rd_wdata);
        errs += check_field("retire_o.next_pc", exp_rec.next_pc, retire_i.next_pc);
        errs += check_field("pc_o", exp_rec.next_pc, pc_i);  // the pc moves with the retire.
        if (errs == 0) begin
          $display("test %0d passed at %0d ns", test_num, $time);
          pass_count_o <= pass_count_o + 1;
        end else begin
          $display("test %0d failed with %0d mismatches", test_num, errs);
          fail_count_o <= fail_count_o + 1;
        end
      end
    end
    pending_o <= exp_q.size();
  end

endmodule

`default_nettype wire

// File: dv/tb_sys_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sys_core;

  localparam string PATTERN_FILE = "dv/sys_patterns.txt";
  localparam int    MAX_TESTS    = 64;
  localparam int    MAX_GAP      = 3;

  logic             clk;
  logic             reset;
  logic             instr_valid;
  sys_pkg::xlen_t   instr;
  logic             retire_valid;
  sys_pkg::retire_t retire;
  sys_pkg::xlen_t   pc;
  logic             exp_valid;
  logic [15:0]      exp_test;
  sys_pkg::retire_t exp_rec;
  int               pass_count;
  int               fail_count;
  int               extra_count;
  int               pending;
  int               seed = 32'h367c_e72d;
  int               cycle_count = 0;
  int               cycle_limit = 0;

  logic [15:0]      test_mem  [MAX_TESTS];
  sys_pkg::xlen_t   instr_mem [MAX_TESTS];
  sys_pkg::retire_t exp_mem   [MAX_TESTS];

  sys_core i_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .retire_valid_o (retire_valid),
    .retire_o       (retire),
    .pc_o           (pc)
  );

  sys_checker i_checker (
    .clk_i          (clk),
    .retire_valid_i (retire_valid),
    .retire_i       (retire),
    .pc_i           (pc),
    .exp_valid_i    (exp_valid),
    .exp_test_i     (exp_test),
    .exp_i          (exp_rec),
    .pass_count_o   (pass_count),
    .fail_count_o   (fail_count),
    .extra_count_o  (extra_count),
    .pending_o      (pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // lines that do not hold all seven columns are skipped.
  task automatic load_patterns(output int count);
    int             fd;
    int             rc;
    int             t;
    int             we;
    int             rd;
    string          line;
    sys_pkg::xlen_t w;
    sys_pkg::xlen_t wd;
    sys_pkg::xlen_t p;
    sys_pkg::xlen_t np;
    count = 0;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd) && count < MAX_TESTS) begin
        line = "";
        rc = $fgets(line, fd);
        rc = $sscanf(line, "%d %h %d %d %h %h %h", t, w, we, rd, wd, p, np);
        if (rc == 7) begin
          test_mem[count]          = t[15:0];
          instr_mem[count]         = w;
          exp_mem[count].pc        = p;
          exp_mem[count].rd_we     = we[0];
          exp_mem[count].rd        = rd[4:0];
          exp_mem[count].rd_wdata  = wd;
          exp_mem[count].next_pc   = np;
          count++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ******************************
  // stimulus
  // ******************************
  initial begin
    int count;
    int gap;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_test    = '0;
    exp_rec     = '0;
    load_patterns(count);
    if (count == 0) begin
      $display("no patterns could be read from %s", PATTERN_FILE);
      $display("*** TEST FAILED ***");
      $finish;
    end else begin
      cycle_limit = 2 * count + count * MAX_GAP + 20;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      for (int i = 0; i < count; i++) begin
        gap = (i % 2 == 1) ? 0 : int'($unsigned($random(seed)) % (MAX_GAP + 1));
        repeat (gap) begin
          @(posedge clk);
          instr_valid <= 1'b0;
          exp_valid   <= 1'b0;
        end
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= instr_mem[i];
        exp_valid   <= 1'b1;
        exp_test    <= test_mem[i];
        exp_rec     <= exp_mem[i];
      end
      @(posedge clk);
      instr_valid <= 1'b0;
      exp_valid   <= 1'b0;
      while (pass_count + fail_count < count) @(posedge clk);
      repeat (2) @(posedge clk);  // a stray retire would show up here.
      if (pending != 0) begin
        $display("%0d expected records were never retired", pending);
      end
      $display("tests %0d, passed %0d, failed %0d, unexpected retires %0d",
               count, pass_count, fail_count, extra_count);
      if (pass_count == count && fail_count == 0 && extra_count == 0 && pending == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("timeout after %0d cycles with %0d records still open", cycle_count, pending);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/sys_patterns.txt
# test instr rd_we rd rd_wdata pc next_pc
# test, rd_we and rd are decimal, the other columns are hex.
1 10000093 1 1 00000100 00000000 00000004
2 02308093 1 1 00000123 00000004 00000008
3 fff08113 1 2 00000122 00000008 0000000c
4 00508013 0 0 00000000 0000000c 00000010
5 00700193 1 3 00000007 00000010 00000014
6 20100213 1 4 00000201 00000014 00000018
7 305212f3 1 5 00000000 00000018 0000001c
8 30502373 1 6 00000201 0000001c 00000020
9 3051a3f3 1 7 00000201 00000020 00000024
10 30502473 1 8 00000207 00000024 00000028
11 00800493 1 9 00000008 00000028 0000002c
12 30049073 0 0 00000000 0000002c 00000030
13 30002573 1 10 00000008 00000030 00000034
14 341095f3 1 11 00000000 00000034 00000038
15 34219673 1 12 00000000 00000038 0000003c
16 341026f3 1 13 00000123 0000003c 00000040
17 34202773 1 14 00000007 00000040 00000044
18 f11097f3 1 15 79737978 00000044 00000048
19 f1102873 1 16 79737978 00000048 0000004c
20 f12028f3 1 17 01509be8 0000004c 00000050
21 7c009973 1 18 00000000 00000050 00000054
22 00000073 0 0 00000000 00000054 00000204
23 341029f3 1 19 00000054 00000204 00000208
24 34202a73 1 20 0000000b 00000208 0000020c
25 30002af3 1 21 00000080 0000020c 00000210
26 00498b13 1 22 00000058 00000210 00000214
27 341b1073 0 0 00000000 00000214 00000218
28 30200073 0 0 00000000 00000218 00000058
29 30002bf3 1 23 00000088 00000058 0000005c
30 0000ac03 0 0 00000000 0000005c 00000060
31 00110c93 1 25 00000123 00000060 00000064

// File: sim.f
verilog/sys_pkg.sv
verilog/reg_file.sv
verilog/csr_file.sv
verilog/pc_unit.sv
verilog/sys_control.sv
verilog/sys_core.sv
dv/sys_checker.sv
dv/tb_sys_core.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the sys_core testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f sim.f --top-module tb_sys_core

./obj_dir/Vtb_sys_core | tee sim.log

if grep -q -F "*** TEST FAILED ***" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q -F "*** TEST PASSED ***" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"
